/* project.f */
hdl/core_pkg.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/data_mem.sv
hdl/csr_file.sv
hdl/top_arty.sv
sim/tb_clk.sv
sim/top_arty_chk.sv
sim/tb_top.sv

/* sim/prog.hex */
// one 32-bit instruction word per line, word index 0 first
00A00213
01000293
8002A073
8002B073
801020F3
0040C0B3
00102023
00002103
0051C1B3
00316133
80011073
0080006F
80001073
FC021EE3

/* sim/tb_top.sv */
// tb_top: testbench top with clock, DUT, lfsr button stimulus, final led check and watchdog
`timescale 1ns/100ps

module tb_top;

  localparam int num_values = 40;
  localparam int hold_min = 20;
  // one drive cycle plus at most 35 hold cycles
  localparam int max_cycles_per_value = 36;
  localparam int watchdog_cycles = num_values * max_cycles_per_value + 100;
  localparam logic [31:0] lfsr_seed = 32'hb18a_b191;
  localparam core_pkg::led_t led_mask = 4'b1010;

  logic           clk;
  logic           rst;
  core_pkg::btn_t btn;
  core_pkg::led_t led;
  logic           rx;

  logic [31:0]    lfsr_state;
  core_pkg::btn_t last_btn;
  int             direct_errors;

  tb_clk i_clk (
    .clk(clk),
    .rst(rst)
  );

  top_arty i_dut (
    .clk(clk),
    .rst(rst),
    .btn(btn),
    .led(led),
    .rx (rx)
  );

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  initial begin
    logic [31:0]    rnd;
    int             hold;
    int             assert_errors;
    core_pkg::led_t expected;
    btn           = '0;
    lfsr_state    = lfsr_seed;
    last_btn      = '0;
    direct_errors = 0;
    wait (rst == 1'b0);
    for (int v = 0; v < num_values; v++) begin
      draw_bits(4, rnd);
      last_btn = rnd[3:0];
      // hold 20 to 35 cycles
      draw_bits(4, rnd);
      hold = hold_min + int'(rnd[3:0]);
      @(posedge clk);
      #1;
      btn = last_btn;
      repeat (hold) @(posedge clk);
    end
    // led settled long before the end of the last hold
    #1;
    expected = last_btn ^ led_mask;
    if (led !== expected) begin
      direct_errors++;
      $display("Fail led_final expected %h actual %h", expected, led);
    end
    assert_errors = i_dut.i_chk.fail_count;
    $display("errors: %0d assertion, %0d direct", assert_errors, direct_errors);
    if (assert_errors + direct_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // ends a run that overruns the longest possible stimulus
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: stimulus did not finish within %0d cycles", watchdog_cycles);
    $display("errors: %0d assertion, %0d direct", i_dut.i_chk.fail_count, direct_errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* sim/top_arty_chk.sv */
// top_arty_chk: bound assertions on reset state, rx pulse, loop period, led data path and trap word
`timescale 1ns/100ps

module top_arty_chk (
  input logic           clk,
  input logic           rst,
  input core_pkg::btn_t btn,
  input core_pkg::led_t led,
  input logic           rx
);

  // failed assertions, read by the testbench top
  int fail_count = 0;

  // cycles since reset release, saturating
  logic [7:0]     cyc;
  // values at the previous edge
  core_pkg::btn_t btn_prev;
  core_pkg::led_t led_prev;
  logic           rx_prev;
  // run lengths, in edges
  logic [7:0]     btn_hold;
  logic [7:0]     rx_hold;
  // edges since btn last showed 4'b1010, the value that clears led
  logic [7:0]     clear_btn_age;

  always_ff @(posedge clk) begin
    btn_prev <= btn;
    led_prev <= led;
    rx_prev  <= rx;
    if (rst) begin
      cyc           <= '0;
      btn_hold      <= '0;
      rx_hold       <= '0;
      clear_btn_age <= '1;
    end else begin
      if (cyc != '1) begin
        cyc <= cyc + 8'd1;
      end
      // restart on change, else count up to saturation
      if (btn != btn_prev) begin
        btn_hold <= '0;
      end else if (btn_hold != '1) begin
        btn_hold <= btn_hold + 8'd1;
      end
      if (rx != rx_prev) begin
        rx_hold <= '0;
      end else if (rx_hold != '1) begin
        rx_hold <= rx_hold + 8'd1;
      end
      if (btn == 4'b1010) begin
        clear_btn_age <= '0;
      end else if (clear_btn_age != '1) begin
        clear_btn_age <= clear_btn_age + 8'd1;
      end
    end
  end

  // outputs held low by reset
  a_reset_state: assert property (@(posedge clk) rst |=> (led == '0 && !rx))
    else begin
      fail_count++;
      $error("Fail reset_state expected led 0 rx 0 actual led %h rx %b",
             $sampled(led), $sampled(rx));
    end

  // csrrs at word 2 sets rx, csrrc at word 3 clears it one cycle later
  a_rx_pulse: assert property (@(posedge clk)
      $fell(rst) |-> !rx ##1 !rx ##1 !rx ##1 rx ##1 !rx)
    else begin
      fail_count++;
      $error("rx was not a one-cycle pulse in cycle 3 after reset release");
    end

  // 16 stable samples always cover one full loop from btn read to led write
  a_data_path: assert property (@(posedge clk)
      (!rst && btn_hold >= 8'd14 && btn == btn_prev) |-> led == (btn ^ 4'b1010))
    else begin
      fail_count++;
      $error("Fail data_path expected %h actual %h",
             $sampled(btn) ^ 4'b1010, $sampled(led));
    end

  // loop toggles rx, the first loop change at cycle 11 is skipped
  a_loop_period: assert property (@(posedge clk)
      (!rst && cyc > 8'd12 && rx != rx_prev) |-> rx_hold == 8'd8)
    else begin
      fail_count++;
      $error("Fail loop_period expected 9 actual %0d", $sampled(rx_hold) + 1);
    end

  a_loop_alive: assert property (@(posedge clk)
      (!rst && cyc > 8'd12) |-> rx_hold <= 8'd8)
    else begin
      fail_count++;
      $error("rx stayed unchanged for more than 9 cycles, loop is not running");
    end

  // led only drops to zero through the data path, never via word 12
  a_no_trap: assert property (@(posedge clk)
      (!rst && led_prev != '0 && led == '0) |-> clear_btn_age < 8'd9)
    else begin
      fail_count++;
      $error("led was cleared without btn 4'b1010 in the previous 9 cycles");
    end

endmodule

bind top_arty top_arty_chk i_chk (
  .clk(clk),
  .rst(rst),
  .btn(btn),
  .led(led),
  .rx (rx)
);

/* sim/tb_clk.sv */
// tb_clk: testbench clock and synchronous reset generator
`timescale 1ns/100ps

module tb_clk (
  output logic clk,
  output logic rst
);

  // 4 ns period
  localparam int half_period = 2;
  localparam int reset_cycles = 4;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // release 1 ns after the last reset edge
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

/* hdl/top_arty.sv */
// top_arty: single-cycle core top with pc, next-pc logic, rom, write-back and block instances
`timescale 1ns/100ps

module top_arty (
  input  logic           clk,
  input  logic           rst,
  input  core_pkg::btn_t btn,
  output core_pkg::led_t led,
  output logic           rx
);

  // fetch
  core_pkg::word        pc;
  core_pkg::word        pc_plus4;
  core_pkg::word        pc_target;
  core_pkg::word        pc_next;
  core_pkg::imem_addr_t rom_addr;
  core_pkg::word        instr;
  core_pkg::word        rom [core_pkg::imem_depth];

  // decode
  core_pkg::reg_addr_t  rs1;
  core_pkg::reg_addr_t  rs2;
  core_pkg::reg_addr_t  rd;
  core_pkg::word        imm;
  core_pkg::alu_op_t    alu_op;
  logic                 alu_b_imm;
  logic                 mem_write_enable;
  logic                 branch_ne;
  logic                 jump;
  logic                 csr_enable;
  core_pkg::csr_op_t    csr_op;
  core_pkg::csr_addr_t  csr_addr;
  core_pkg::wb_sel_t    wb_sel;
  logic                 wb_write_enable;

  // execute and write-back
  core_pkg::word        rs1_data;
  core_pkg::word        rs2_data;
  core_pkg::word        res;
  logic                 not_equal;
  core_pkg::word        mem_data;
  core_pkg::word        csr_data;
  core_pkg::word        wb_data;
  logic [core_pkg::led_width:0] led_reg;

  // program image, byte pc to word index
  initial $readmemh("sim/prog.hex", rom);
  assign rom_addr = pc[$bits(core_pkg::imem_addr_t)+1:2];
  assign instr    = rom[rom_addr];

  // jal and taken bne share the pc-relative target
  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;
  assign pc_next   = (jump || (branch_ne && not_equal)) ? pc_target : pc_plus4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  decoder i_decoder (
    .instr           (instr),
    .rs1             (rs1),
    .rs2             (rs2),
    .rd              (rd),
    .imm             (imm),
    .alu_op          (alu_op),
    .alu_b_imm       (alu_b_imm),
    .mem_write_enable(mem_write_enable),
    .branch_ne       (branch_ne),
    .jump            (jump),
    .csr_enable      (csr_enable),
    .csr_op          (csr_op),
    .csr_addr        (csr_addr),
    .wb_sel          (wb_sel),
    .wb_write_enable (wb_write_enable)
  );

  reg_file i_reg_file (
    .clk         (clk),
    .rst         (rst),
    .write_enable(wb_write_enable),
    .write_addr  (rd),
    .read_addr1  (rs1),
    .read_addr2  (rs2),
    .write_data  (wb_data),
    .read_data1  (rs1_data),
    .read_data2  (rs2_data)
  );

  alu i_alu (
    .a        (rs1_data),
    .b_reg    (rs2_data),
    .imm      (imm),
    .b_imm    (alu_b_imm),
    .op       (alu_op),
    .res      (res),
    .not_equal(not_equal)
  );

  // word aligned byte address to word index
  data_mem i_data_mem (
    .clk         (clk),
    .write_enable(mem_write_enable),
    .address     (res[$bits(core_pkg::dmem_addr_t)+1:2]),
    .write_data  (rs2_data),
    .read_data   (mem_data)
  );

  csr_file i_csr_file (
    .clk        (clk),
    .rst        (rst),
    .csr_enable (csr_enable),
    .csr_op     (csr_op),
    .csr_addr   (csr_addr),
    .write_value(rs1_data),
    .btn        (btn),
    .read_data  (csr_data),
    .led_reg    (led_reg)
  );

  // write-back source
  always_comb begin
    case (wb_sel)
      core_pkg::wb_alu: wb_data = res;
      core_pkg::wb_mem: wb_data = mem_data;
      core_pkg::wb_csr: wb_data = csr_data;
      core_pkg::wb_pc4: wb_data = pc_plus4;
      default:          wb_data = res;
    endcase
  end

  // top csr bit is the rx pin
  assign led = led_reg[core_pkg::led_width-1:0];
  assign rx  = led_reg[core_pkg::led_width];

endmodule

/* hdl/csr_file.sv */
// csr_file: led/rx read-write csr and read-only button csr
`timescale 1ns/100ps

module csr_file (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        csr_enable,
  input  core_pkg::csr_op_t           csr_op,
  input  core_pkg::csr_addr_t         csr_addr,
  input  core_pkg::word               write_value,
  input  core_pkg::btn_t              btn,
  output core_pkg::word               read_data,
  output logic [core_pkg::led_width:0] led_reg
);

  // low bits of rs1, one per led plus rx
  logic [core_pkg::led_width:0] wr_bits;
  logic [core_pkg::led_width:0] led_next;
  logic                         led_access;

  assign wr_bits    = write_value[core_pkg::led_width:0];
  assign led_access = csr_enable && (csr_addr == core_pkg::led_csr_addr);

  // write, set or clear
  always_comb begin
    case (csr_op)
      core_pkg::csr_rw: led_next = wr_bits;
      core_pkg::csr_rs: led_next = led_reg | wr_bits;
      core_pkg::csr_rc: led_next = led_reg & ~wr_bits;
      default:          led_next = led_reg;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      led_reg <= '0;
    end else if (led_access) begin
      led_reg <= led_next;
    end
  end

  // old value out, zero extended
  // button csr ignores writes
  always_comb begin
    case (csr_addr)
      core_pkg::led_csr_addr:
        read_data = {{(core_pkg::xlen - core_pkg::led_width - 1){1'b0}}, led_reg};
      core_pkg::btn_csr_addr:
        read_data = {{(core_pkg::xlen - core_pkg::btn_width){1'b0}}, btn};
      default:
        read_data = '0;
    endcase
  end

endmodule

/* hdl/data_mem.sv */
// data_mem: 16-word data ram, sync write, async read
`timescale 1ns/100ps

module data_mem (
  input  logic                 clk,
  input  logic                 write_enable,
  input  core_pkg::dmem_addr_t address,
  input  core_pkg::word        write_data,
  output core_pkg::word        read_data
);

  core_pkg::word mem [core_pkg::dmem_depth];

  // store commits at the end of the cycle
  always_ff @(posedge clk) begin
    if (write_enable) begin
      mem[address] <= write_data;
    end
  end

  // load data visible in the same cycle
  assign read_data = mem[address];

endmodule

/* hdl/alu.sv */
// alu: operand b selection, add/sub/and/or/xor and the bne compare
`timescale 1ns/100ps

module alu (
  input  core_pkg::word     a,
  input  core_pkg::word     b_reg,
  input  core_pkg::word     imm,
  input  logic              b_imm,
  input  core_pkg::alu_op_t op,
  output core_pkg::word     res,
  output logic              not_equal
);

  core_pkg::word b;

  // immediate or rs2
  assign b = b_imm ? imm : b_reg;

  always_comb begin
    case (op)
      core_pkg::alu_add: res = a + b;
      core_pkg::alu_sub: res = a - b;
      core_pkg::alu_and: res = a & b;
      core_pkg::alu_or:  res = a | b;
      core_pkg::alu_xor: res = a ^ b;
      default:           res = a + b;
    endcase
  end

  // bne always compares the two registers
  assign not_equal = (a != b_reg);

endmodule

/* hdl/reg_file.sv */
// reg_file: 32 x 32-bit registers, two async reads, one sync write, x0 tied to zero
`timescale 1ns/100ps

module reg_file (
  input  logic                clk,
  input  logic                rst,
  input  logic                write_enable,
  input  core_pkg::reg_addr_t write_addr,
  input  core_pkg::reg_addr_t read_addr1,
  input  core_pkg::reg_addr_t read_addr2,
  input  core_pkg::word       write_data,
  output core_pkg::word       read_data1,
  output core_pkg::word       read_data2
);

  core_pkg::word regs [32];

  // write at the edge ending the instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && (write_addr != '0)) begin
      regs[write_addr] <= write_data;
    end
  end

  // x0 reads as zero
  assign read_data1 = (read_addr1 == '0) ? '0 : regs[read_addr1];
  assign read_data2 = (read_addr2 == '0) ? '0 : regs[read_addr2];

endmodule

/* hdl/decoder.sv */
// decoder: instruction fields, immediate generation and control signals
`timescale 1ns/100ps

module decoder (
  input  core_pkg::word       instr,
  output core_pkg::reg_addr_t rs1,
  output core_pkg::reg_addr_t rs2,
  output core_pkg::reg_addr_t rd,
  output core_pkg::word       imm,
  output core_pkg::alu_op_t   alu_op,
  output logic                alu_b_imm,
  output logic                mem_write_enable,
  output logic                branch_ne,
  output logic                jump,
  output logic                csr_enable,
  output core_pkg::csr_op_t   csr_op,
  output core_pkg::csr_addr_t csr_addr,
  output core_pkg::wb_sel_t   wb_sel,
  output logic                wb_write_enable
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  // set when the instruction produces a result for rd
  logic       writes_rd;

  // fixed field positions
  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign rd       = instr[11:7];
  assign rs1      = instr[19:15];
  assign rs2      = instr[24:20];
  assign csr_addr = instr[31:20];

  always_comb begin
    // defaults: nop, nothing written
    imm              = '0;
    alu_op           = core_pkg::alu_add;
    alu_b_imm        = 1'b0;
    mem_write_enable = 1'b0;
    branch_ne        = 1'b0;
    jump             = 1'b0;
    csr_enable       = 1'b0;
    csr_op           = core_pkg::csr_rw;
    wb_sel           = core_pkg::wb_alu;
    writes_rd        = 1'b0;

    case (opcode)
      core_pkg::op_imm, core_pkg::op_reg: begin
        // i-type immediate, only used for op_imm
        imm       = {{20{instr[31]}}, instr[31:20]};
        alu_b_imm = (opcode == core_pkg::op_imm);
        writes_rd = 1'b1;
        case (funct3)
          core_pkg::f3_xor: alu_op = core_pkg::alu_xor;
          core_pkg::f3_or:  alu_op = core_pkg::alu_or;
          core_pkg::f3_and: alu_op = core_pkg::alu_and;
          core_pkg::f3_add: begin
            // sub only in register form, funct7 bit 5
            if (opcode == core_pkg::op_reg && instr[30]) begin
              alu_op = core_pkg::alu_sub;
            end
          end
          default: alu_op = core_pkg::alu_add;
        endcase
      end
      core_pkg::op_load: begin
        // address = rs1 + imm
        imm       = {{20{instr[31]}}, instr[31:20]};
        alu_b_imm = 1'b1;
        wb_sel    = core_pkg::wb_mem;
        writes_rd = 1'b1;
      end
      core_pkg::op_store: begin
        // s-type immediate
        imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        alu_b_imm        = 1'b1;
        mem_write_enable = 1'b1;
      end
      core_pkg::op_jal: begin
        // j-type, bit 0 implied zero
        imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                     instr[30:21], 1'b0};
        jump      = 1'b1;
        wb_sel    = core_pkg::wb_pc4;
        writes_rd = 1'b1;
      end
      core_pkg::op_branch: begin
        // b-type, only bne supported
        imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                     instr[11:8], 1'b0};
        branch_ne = (funct3 == core_pkg::f3_bne);
      end
      core_pkg::op_system: begin
        // csr reads go to rd, old value returned
        wb_sel = core_pkg::wb_csr;
        case (funct3)
          core_pkg::f3_csrrw: begin
            csr_enable = 1'b1;
            csr_op     = core_pkg::csr_rw;
            writes_rd  = 1'b1;
          end
          core_pkg::f3_csrrs: begin
            csr_enable = 1'b1;
            csr_op     = core_pkg::csr_rs;
            writes_rd  = 1'b1;
          end
          core_pkg::f3_csrrc: begin
            csr_enable = 1'b1;
            csr_op     = core_pkg::csr_rc;
            writes_rd  = 1'b1;
          end
          default: csr_enable = 1'b0;
        endcase
      end
      default: writes_rd = 1'b0;
    endcase
  end

  // x0 is never written
  assign wb_write_enable = writes_rd && (rd != '0);

endmodule

/* hdl/core_pkg.sv */
// core_pkg: widths, vector typedefs, opcodes, funct3 codes, csr addresses, control enums
package core_pkg;

  // data path width
  localparam int xlen = 32;
  typedef logic [xlen-1:0] word;

  // register file index
  typedef logic [4:0] reg_addr_t;

  // instruction rom, 64 words
  localparam int imem_depth = 64;
  typedef logic [$clog2(imem_depth)-1:0] imem_addr_t;

  // data memory, 16 words
  localparam int dmem_depth = 16;
  typedef logic [$clog2(dmem_depth)-1:0] dmem_addr_t;

  // csr address space
  typedef logic [11:0] csr_addr_t;

  // board io
  localparam int led_width = 4;
  localparam int btn_width = 4;
  typedef logic [led_width-1:0] led_t;
  typedef logic [btn_width-1:0] btn_t;

  // custom read/write csr, bit 4 drives rx
  localparam csr_addr_t led_csr_addr = 12'h800;
  // read-only button csr
  localparam csr_addr_t btn_csr_addr = 12'h801;

  // major opcodes, instr[6:0]
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 for alu ops
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct3 for branches
  localparam logic [2:0] f3_bne = 3'b001;

  // funct3 for csr access, register source only
  localparam logic [2:0] f3_csrrw = 3'b001;
  localparam logic [2:0] f3_csrrs = 3'b010;
  localparam logic [2:0] f3_csrrc = 3'b011;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor
  } alu_op_t;

  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_csr,
    wb_pc4
  } wb_sel_t;

  typedef enum logic [1:0] {
    csr_rw,
    csr_rs,
    csr_rc
  } csr_op_t;

endpackage
